//--- bench/cacheChecker.sv
`default_nettype none

module cacheChecker (
	input  wire                    CLK,
	input  wire                    RST_N,
	input  wire cachePkg::cpuReq_t cpu,
	input  wire [31:0]             cpuRdata,
	input  wire                    cpuDone,
	input  wire cachePkg::memReq_t mem,
	input  wire                    memReq,
	input  wire                    memWait,
	input  wire [2:0]              expBeats,
	input  wire [31:0]             expData,
	output int                     dataErrors,
	output int                     beatErrors
);

	int beats;

	function automatic bit mismatch(input string name, input logic [31:0] got,
	                                input logic [31:0] exp);
		if (got !== exp)
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		return got !== exp;
	endfunction

	task automatic checkBeat(input int idx);
		logic [31:0] expAddr;
		logic [1:0]  word;
		if (idx >= expBeats) begin
			$display("unexpected memory beat at %0t, address %h", $time, mem.addr);
			beatErrors++;
		end else if (expBeats == 3'd4) begin
			// fill walks the line from the word after the requested one
			word    = cpu.addr[3:2] + 2'(idx + 1);
			expAddr = {cpu.addr[31:4], word, 2'b00};
			beatErrors += mismatch("mem.addr", mem.addr, expAddr);
			beatErrors += mismatch("mem.we", mem.we, 1'b0);
			beatErrors += mismatch("mem.lock", mem.lock, idx < 3);
		end else begin
			beatErrors += mismatch("mem.addr", mem.addr, cpu.addr);
			beatErrors += mismatch("mem.we", mem.we, cpu.write);
			beatErrors += mismatch("mem.lock", mem.lock, 1'b0);
			if (cpu.write) begin
				beatErrors += mismatch("mem.wdata", mem.wdata, cpu.wdata);
				beatErrors += mismatch("mem.be", mem.be, cpu.be);
			end
		end
	endtask

	initial begin
		dataErrors = 0;
		beatErrors = 0;
		beats      = 0;
	end

	// outputs are settled at the falling edge
	always @(negedge CLK) begin
		if (RST_N) begin
			if (memReq && !memWait) begin
				checkBeat(beats);
				beats++;
			end
			if (cpuDone) begin
				if (beats != expBeats) begin
					$display("request to %h finished after %0d memory beats, expected %0d",
					         cpu.addr, beats, expBeats);
					beatErrors++;
				end
				if (!cpu.write)
					dataErrors += mismatch("cpuRdata", cpuRdata, expData);
				beats = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/cacheTopTb.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheTopTb;

	localparam int requestCount = 40;
	localparam int cycleLimit   = requestCount * 40;

	logic              CLK;
	logic              RST_N;
	logic              cpuReq;
	cachePkg::cpuReq_t cpu;
	wire [31:0]        cpuRdata;
	wire               cpuDone;
	wire cachePkg::memReq_t mem;
	wire               memReq;
	logic              memWait;
	logic [31:0]       memRdata;
	logic [2:0]        expBeats;
	logic [31:0]       expData;
	int                dataErrors;
	int                beatErrors;
	int                cycles;

	// word-addressed, sparse
	logic [31:0] backing [logic [31:0]];
	logic [31:0] shadow  [logic [31:0]];

	cacheTop cacheTop_inst (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cpuReq   (cpuReq),
		.cpu      (cpu),
		.cpuRdata (cpuRdata),
		.cpuDone  (cpuDone),
		.mem      (mem),
		.memReq   (memReq),
		.memWait  (memWait),
		.memRdata (memRdata)
	);

	cacheChecker cacheChecker_inst (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cpu        (cpu),
		.cpuRdata   (cpuRdata),
		.cpuDone    (cpuDone),
		.mem        (mem),
		.memReq     (memReq),
		.memWait    (memWait),
		.expBeats   (expBeats),
		.expData    (expData),
		.dataErrors (dataErrors),
		.beatErrors (beatErrors)
	);

	// unwritten words, a rotate of the whole address
	function automatic logic [31:0] fillPattern(input logic [31:0] addr);
		return {addr[12:0], addr[31:13]} ^ 32'h3c5a96e1;
	endfunction

	function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
	                                           input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] backingWord(input logic [31:0] addr);
		logic [31:0] word;
		word = {addr[31:2], 2'b00};
		return backing.exists(word) ? backing[word] : fillPattern(word);
	endfunction

	// reference value of a read
	function automatic logic [31:0] expectedRead(input logic [31:0] addr);
		logic [31:0] word;
		word = {addr[31:2], 2'b00};
		return shadow.exists(word) ? shadow[word] : fillPattern(word);
	endfunction

	task automatic access(input logic isWrite, input logic [31:0] addr, input logic [31:0] data,
	                      input logic [3:0] be, input int beats);
		expBeats = 3'(beats);
		expData  = isWrite ? 32'h0 : expectedRead(addr);
		// purge-area writes never reach memory
		if (isWrite && addr[31:29] != `AREA_PURGE)
			shadow[{addr[31:2], 2'b00}] = mergeBytes(expectedRead(addr), data, be);
		cpu    = '{addr: addr, wdata: data, be: be, write: isWrite};
		cpuReq = 1'b1;
		do
			@(negedge CLK);
		while (!cpuDone);
		@(posedge CLK);
		#10;
		cpuReq = 1'b0;
		@(posedge CLK);
		#10;
	endtask

	// memory side, 0 to 3 wait cycles per beat
	task automatic runMemory();
		logic beatNow;
		int   waitLeft;
		waitLeft = $urandom_range(3);
		forever begin
			@(negedge CLK);
			beatNow = memReq && !memWait;
			if (beatNow && mem.we)
				backing[{mem.addr[31:2], 2'b00}] = mergeBytes(backingWord(mem.addr), mem.wdata,
				                                              mem.be);
			@(posedge CLK);
			#10;
			if (beatNow)
				waitLeft = $urandom_range(3);
			memWait  = !(memReq && waitLeft == 0);
			memRdata = backingWord(mem.addr);
			if (memReq && waitLeft > 0)
				waitLeft--;
		end
	endtask

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		for (cycles = 0; cycles < cycleLimit; cycles++)
			@(posedge CLK);
		$display("run did not finish within %0d cycles", cycleLimit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h69a3f1ed));
		RST_N    = 1'b0;
		cpuReq   = 1'b0;
		cpu      = '0;
		memWait  = 1'b1;
		memRdata = 32'h0;
		expBeats = 3'd0;
		expData  = 32'h0;
		fork
			runMemory();
		join_none
		repeat (10) @(posedge CLK);
		#10;
		RST_N = 1'b1;
		@(posedge CLK);
		#10;
		// CE is clear out of reset
		access(1'b0, 32'h0000_0104, 32'h0, 4'hF, 1);
		access(1'b0, 32'h0000_0104, 32'h0, 4'hF, 1);
		access(1'b1, `CCR_ADDR, 32'h0000_0100, 4'b0010, 1);
		access(1'b0, 32'h0000_0108, 32'h0, 4'hF, 4);
		for (int w = 0; w < 4; w++)
			access(1'b0, 32'h0000_0100 + 4 * w, 32'h0, 4'hF, 0);
		// write-through in each area, partial lanes merged
		access(1'b1, 32'h0000_0104, $urandom, 4'b0101, 1);
		access(1'b0, 32'h0000_0104, 32'h0, 4'hF, 0);
		access(1'b1, 32'h2000_0040, $urandom, 4'hF, 1);
		access(1'b0, 32'h2000_0040, 32'h0, 4'hF, 1);
		access(1'b1, 32'h2000_0040, $urandom, 4'b1000, 1);
		access(1'b0, 32'h2000_0040, 32'h0, 4'hF, 1);
		access(1'b0, 32'hE000_0010, 32'h0, 4'hF, 1);
		access(1'b1, 32'hE000_0010, $urandom, 4'b0011, 1);
		access(1'b0, 32'hE000_0010, 32'h0, 4'hF, 1);
		access(1'b1, 32'h0000_3310, $urandom, 4'b1100, 1);
		access(1'b0, 32'h0000_3310, 32'h0, 4'hF, 4);
		// five tags in set 0x20
		for (int t = 1; t <= 5; t++)
			access(1'b0, (t << 10) | 32'h200, 32'h0, 4'hF, 4);
		access(1'b0, 32'h0000_0600, 32'h0, 4'hF, 4);
		for (int t = 3; t <= 5; t++)
			access(1'b0, (t << 10) | 32'h200, 32'h0, 4'hF, 0);
		// cache off bypasses valid lines
		access(1'b1, `CCR_ADDR, 32'h0, 4'b0010, 1);
		access(1'b0, 32'h0000_0E00, 32'h0, 4'hF, 1);
		access(1'b0, 32'h0000_0108, 32'h0, 4'hF, 1);
		access(1'b1, `CCR_ADDR, 32'h0000_0100, 4'b0010, 1);
		access(1'b0, 32'h0000_0108, 32'h0, 4'hF, 0);
		access(1'b1, 32'h4000_0108, 32'h0, 4'hF, 0);
		access(1'b0, 32'h0000_0108, 32'h0, 4'hF, 4);
		access(1'b0, 32'h0000_0100, 32'h0, 4'hF, 0);
		// purge-all, CE stays on
		access(1'b1, `CCR_ADDR, 32'h0000_1100, 4'b0010, 1);
		access(1'b0, 32'h0000_0104, 32'h0, 4'hF, 4);
		access(1'b0, 32'h0000_0E00, 32'h0, 4'hF, 4);
		access(1'b0, 32'h0000_3310, 32'h0, 4'hF, 4);
		$display("%0d read data errors, %0d memory beat errors", dataErrors, beatErrors);
		if (dataErrors == 0 && beatErrors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- cacheTop.f
+incdir+hw
hw/cachePkg.sv
hw/fillCounter.sv
hw/tagLru.sv
hw/dataArray.sv
hw/busControl.sv
hw/cacheTop.sv
bench/cacheChecker.sv
bench/cacheTopTb.sv

//--- hw/busControl.sv
`default_nettype none

`include "cache_cfg.svh"

module busControl (
	input  wire                   CLK,
	input  wire                   RST_N,
	input  wire                   cpuReq,
	input  wire cachePkg::cpuReq_t cpu,
	input  wire cachePkg::lookup_t look,
	input  wire [31:0]            hitData,
	input  wire                   memWait,
	input  wire [31:0]            memRdata,
	output logic [31:0]           cpuRdata,
	output logic                  cpuDone,
	output cachePkg::memReq_t     mem,
	output logic                  memReq,
	output cachePkg::arrayCmd_t   cmd,
	output logic                  fillStart,
	output logic [$clog2(`CACHE_LINE_WORDS)-1:0] fillWord,
	output logic                  fillStep,
	input  wire [$clog2(`CACHE_LINE_WORDS)-1:0] beatWord,
	input  wire                   fillLast,
	input  wire                   fillUnlock,
	output logic                  purgeAll
);

	typedef enum logic [2:0] {stIdle, stWrite, stRead, stFill, stRespond} state_t;

	state_t                 state;
	cachePkg::memReq_t      memReg;
	logic [31:0]            readBuf;
	logic [`CACHE_WAYS-1:0] victimWay;
	logic                   ce;
	logic                   cp;

	wire [2:0] area      = cpu.addr[31:29];
	wire       idleReq   = (state == stIdle) && cpuReq;
	wire       cacheOn   = (area == `AREA_CACHED) && ce;
	wire       passWrite = (area == `AREA_CACHED) || (area == `AREA_NOCACHE) ||
	                       (area == `AREA_IO);
	wire       readHit   = idleReq && !cpu.write && cacheOn && look.hit;
	wire       writeHit  = idleReq && cpu.write && cacheOn && look.hit;
	wire       linePurge = idleReq && cpu.write && (area == `AREA_PURGE);
	wire       beatDone  = memReq && !memWait;
	wire       ccrSel    = (memReg.addr == `CCR_ADDR) && memReg.be[1];

	// hit data goes straight out, everything else from the buffer
	assign cpuDone  = readHit || (state == stRespond);
	assign cpuRdata = (state == stIdle) ? hitData : readBuf;
	assign purgeAll = cp;

	assign fillStart = idleReq && !cpu.write && cacheOn && !look.hit;
	assign fillWord  = cpu.addr[3:2];
	assign fillStep  = (state == stFill) && beatDone;

	// fill beats walk the line from the counter
	always_comb begin
		mem = memReg;
		if (state == stFill)
			mem.addr[3:2] = beatWord;
	end

	always_comb begin
		cmd.op   = cachePkg::opNone;
		cmd.set  = cpu.addr[9:4];
		cmd.word = cpu.addr[3:2];
		cmd.way  = look.hitWay;
		cmd.be   = cpu.be;
		cmd.tag  = cpu.addr[28:10];
		cmd.data = cpu.wdata;
		if (readHit) begin
			cmd.op = cachePkg::opReadHit;
		end else if (writeHit) begin
			cmd.op = cachePkg::opWriteHit;
		end else if (linePurge) begin
			cmd.op  = cachePkg::opPurgeLine;
			cmd.way = look.tagWay;
		end else if (fillStep) begin
			cmd.op   = cachePkg::opFill;
			cmd.set  = memReg.addr[9:4];
			cmd.word = beatWord;
			cmd.way  = victimWay;
			cmd.be   = 4'b1111;
			cmd.tag  = memReg.addr[28:10];
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state  <= stIdle;
			memReq <= 1'b0;
			memReg <= '0;
			ce     <= 1'b0;
			cp     <= 1'b0;
		end else begin
			// purge-all lasts one cycle
			if (cp)
				cp <= 1'b0;
			case (state)
				stIdle: begin
					if (idleReq) begin
						if (cpu.write) begin
							if (passWrite) begin
								memReg.addr  <= cpu.addr;
								memReg.wdata <= cpu.wdata;
								memReg.be    <= cpu.be;
								memReg.we    <= 1'b1;
								memReg.lock  <= 1'b0;
								memReq       <= 1'b1;
								state        <= stWrite;
							end else begin
								// purge area, nothing on the bus
								state <= stRespond;
							end
						end else if (cacheOn) begin
							if (!look.hit) begin
								memReg.addr <= {cpu.addr[31:4], 4'b0000};
								memReg.be   <= 4'b1111;
								memReg.we   <= 1'b0;
								memReg.lock <= 1'b1;
								memReq      <= 1'b1;
								state       <= stFill;
							end
						end else begin
							memReg.addr <= cpu.addr;
							memReg.be   <= cpu.be;
							memReg.we   <= 1'b0;
							memReg.lock <= 1'b0;
							memReq      <= 1'b1;
							state       <= stRead;
						end
					end
				end
				stWrite: begin
					if (beatDone) begin
						memReq <= 1'b0;
						state  <= stRespond;
						if (ccrSel) begin
							ce <= memReg.wdata[8 + `CCR_CE_BIT];
							cp <= memReg.wdata[8 + `CCR_CP_BIT];
						end
					end
				end
				stRead: begin
					if (beatDone) begin
						memReq <= 1'b0;
						state  <= stRespond;
					end
				end
				stFill: begin
					if (beatDone) begin
						// last beat goes out unlocked
						if (fillUnlock)
							memReg.lock <= 1'b0;
						if (fillLast) begin
							memReq <= 1'b0;
							state  <= stRespond;
						end
					end
				end
				stRespond: state <= stIdle;
				default:   state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (fillStart)
			victimWay <= look.victimWay;
		if (beatDone && ((state == stRead) || (state == stFill && fillLast)))
			readBuf <= memRdata;
	end

endmodule

`default_nettype wire

//--- hw/cachePkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cachePkg;

	// one CPU request, held until done
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        write;
	} cpuReq_t;

	// one memory beat
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        we;
		logic        lock;
	} memReq_t;

	typedef enum logic [2:0] {
		opNone,
		opFill,
		opWriteHit,
		opReadHit,
		opPurgeLine
	} arrayOp_t;

	// controller to tag and data arrays
	typedef struct packed {
		arrayOp_t                                op;
		logic [$clog2(`CACHE_SETS)-1:0]          set;
		logic [$clog2(`CACHE_LINE_WORDS)-1:0]    word;
		logic [`CACHE_WAYS-1:0]                  way;
		logic [3:0]                              be;
		logic [`CACHE_TAG_BITS-1:0]              tag;
		logic [31:0]                             data;
	} arrayCmd_t;

	// ways are one-hot
	typedef struct packed {
		logic                   hit;
		logic [`CACHE_WAYS-1:0] hitWay;
		logic [`CACHE_WAYS-1:0] tagWay;
		logic [`CACHE_WAYS-1:0] victimWay;
	} lookup_t;

endpackage

`default_nettype wire

//--- hw/cacheTop.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheTop (
	input  wire                 CLK,
	input  wire                 RST_N,
	input  wire                 cpuReq,
	input  wire cachePkg::cpuReq_t cpu,
	output wire [31:0]          cpuRdata,
	output wire                 cpuDone,
	output wire cachePkg::memReq_t mem,
	output wire                 memReq,
	input  wire                 memWait,
	input  wire [31:0]          memRdata
);

	wire cachePkg::lookup_t   look;
	wire cachePkg::arrayCmd_t cmd;
	wire [31:0]               hitData;
	wire                      purgeAll;
	wire                      fillStart;
	wire                      fillStep;
	wire                      fillLast;
	wire                      fillUnlock;
	wire [$clog2(`CACHE_LINE_WORDS)-1:0] fillWord;
	wire [$clog2(`CACHE_LINE_WORDS)-1:0] beatWord;

	busControl busControl_inst (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cpuReq     (cpuReq),
		.cpu        (cpu),
		.look       (look),
		.hitData    (hitData),
		.memWait    (memWait),
		.memRdata   (memRdata),
		.cpuRdata   (cpuRdata),
		.cpuDone    (cpuDone),
		.mem        (mem),
		.memReq     (memReq),
		.cmd        (cmd),
		.fillStart  (fillStart),
		.fillWord   (fillWord),
		.fillStep   (fillStep),
		.beatWord   (beatWord),
		.fillLast   (fillLast),
		.fillUnlock (fillUnlock),
		.purgeAll   (purgeAll)
	);

	fillCounter fillCounter_inst (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.fillStart  (fillStart),
		.fillWord   (fillWord),
		.fillStep   (fillStep),
		.beatWord   (beatWord),
		.fillLast   (fillLast),
		.fillUnlock (fillUnlock)
	);

	tagLru tagLru_inst (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cmd        (cmd),
		.purgeAll   (purgeAll),
		.lookupAddr (cpu.addr),
		.look       (look)
	);

	dataArray dataArray_inst (
		.CLK        (CLK),
		.cmd        (cmd),
		.memRdata   (memRdata),
		.lookupAddr (cpu.addr),
		.hitWay     (look.hitWay),
		.hitData    (hitData)
	);

endmodule

`default_nettype wire

//--- hw/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry
`define CACHE_WAYS       4
`define CACHE_SETS       64
`define CACHE_LINE_WORDS 4
// tag is address bits 28..10
`define CACHE_TAG_BITS   19

// address areas, top three address bits
`define AREA_CACHED  3'd0
`define AREA_NOCACHE 3'd1
`define AREA_PURGE   3'd2
`define AREA_IO      3'd7

// cache control register, byte lane 1
`define CCR_ADDR   32'hFFFFFE92
`define CCR_CE_BIT 0
`define CCR_CP_BIT 4

`endif

//--- hw/dataArray.sv
`default_nettype none

`include "cache_cfg.svh"

module dataArray (
	input  wire                     CLK,
	input  wire cachePkg::arrayCmd_t cmd,
	input  wire [31:0]              memRdata,
	input  wire [31:0]              lookupAddr,
	input  wire [`CACHE_WAYS-1:0]   hitWay,
	output logic [31:0]             hitData
);

	localparam int depth   = `CACHE_SETS * `CACHE_LINE_WORDS;
	localparam int idxBits = $clog2(depth);

	logic [31:0] words [`CACHE_WAYS][depth];

	// word index is set and word together
	wire [idxBits-1:0] wrIdx = {cmd.set, cmd.word};
	wire [idxBits-1:0] rdIdx = lookupAddr[2 +: idxBits];

	always_ff @(posedge CLK) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (cmd.way[w]) begin
				if (cmd.op == cachePkg::opFill) begin
					words[w][wrIdx] <= memRdata;
				end else if (cmd.op == cachePkg::opWriteHit) begin
					for (int b = 0; b < 4; b++) begin
						if (cmd.be[b])
							words[w][wrIdx][8*b +: 8] <= cmd.data[8*b +: 8];
					end
				end
			end
		end
	end

	// hit way is one-hot, or zero on a miss
	always_comb begin
		hitData = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitWay[w])
				hitData = hitData | words[w][rdIdx];
		end
	end

endmodule

`default_nettype wire

//--- hw/fillCounter.sv
`default_nettype none

`include "cache_cfg.svh"

module fillCounter (
	input  wire                                 CLK,
	input  wire                                 RST_N,
	input  wire                                 fillStart,
	input  wire [$clog2(`CACHE_LINE_WORDS)-1:0] fillWord,
	input  wire                                 fillStep,
	output logic [$clog2(`CACHE_LINE_WORDS)-1:0] beatWord,
	output logic                                fillLast,
	output logic                                fillUnlock
);

	logic [$clog2(`CACHE_LINE_WORDS)-1:0] reqWord;

	// first beat is the word after the requested one
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			beatWord <= '0;
			reqWord  <= '0;
		end else if (fillStart) begin
			beatWord <= fillWord + 1'b1;
			reqWord  <= fillWord;
		end else if (fillStep) begin
			beatWord <= beatWord + 1'b1;
		end
	end

	assign fillLast   = (beatWord == reqWord);
	assign fillUnlock = (beatWord == reqWord - 1'b1);

endmodule

`default_nettype wire

//--- hw/tagLru.sv
`default_nettype none

`include "cache_cfg.svh"

module tagLru (
	input  wire                     CLK,
	input  wire                     RST_N,
	input  wire cachePkg::arrayCmd_t cmd,
	input  wire                     purgeAll,
	input  wire [31:0]              lookupAddr,
	output cachePkg::lookup_t       look
);

	localparam int setBits = $clog2(`CACHE_SETS);

	logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_SETS-1:0]     valid [`CACHE_WAYS];
	logic [5:0]                 order [`CACHE_SETS];

	wire [setBits-1:0]         lookSet = lookupAddr[4 +: setBits];
	wire [`CACHE_TAG_BITS-1:0] lookTag = lookupAddr[4 + setBits +: `CACHE_TAG_BITS];

	// pair bits, set means the second way is newer
	// 5: 0/1  4: 0/2  3: 0/3  2: 1/2  1: 1/3  0: 2/3
	function automatic logic [`CACHE_WAYS-1:0] oldestWay(input logic [5:0] o);
		logic [`CACHE_WAYS-1:0] res;
		res = 4'b0001;
		if (o[5] && o[4] && o[3])
			res = 4'b0001;
		else if (!o[5] && o[2] && o[1])
			res = 4'b0010;
		else if (!o[4] && !o[2] && o[0])
			res = 4'b0100;
		else if (!o[3] && !o[1] && !o[0])
			res = 4'b1000;
		return res;
	endfunction

	function automatic logic [5:0] markNewest(input logic [`CACHE_WAYS-1:0] way,
	                                          input logic [5:0] o);
		logic [5:0] res;
		res = o;
		if (way[0]) begin
			res[5] = 1'b0;
			res[4] = 1'b0;
			res[3] = 1'b0;
		end else if (way[1]) begin
			res[5] = 1'b1;
			res[2] = 1'b0;
			res[1] = 1'b0;
		end else if (way[2]) begin
			res[4] = 1'b1;
			res[2] = 1'b1;
			res[0] = 1'b0;
		end else if (way[3]) begin
			res[3] = 1'b1;
			res[1] = 1'b1;
			res[0] = 1'b1;
		end
		return res;
	endfunction

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			look.tagWay[w] = (tags[w][lookSet] == lookTag);
			look.hitWay[w] = look.tagWay[w] & valid[w][lookSet];
		end
		look.hit       = |look.hitWay;
		look.victimWay = oldestWay(order[lookSet]);
	end

	always_ff @(posedge CLK) begin
		if (cmd.op == cachePkg::opFill) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (cmd.way[w])
					tags[w][cmd.set] <= cmd.tag;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int w = 0; w < `CACHE_WAYS; w++)
				valid[w] <= '0;
			for (int s = 0; s < `CACHE_SETS; s++)
				order[s] <= '0;
		end else if (purgeAll) begin
			for (int w = 0; w < `CACHE_WAYS; w++)
				valid[w] <= '0;
			for (int s = 0; s < `CACHE_SETS; s++)
				order[s] <= '0;
		end else begin
			case (cmd.op)
				cachePkg::opFill: begin
					for (int w = 0; w < `CACHE_WAYS; w++) begin
						if (cmd.way[w])
							valid[w][cmd.set] <= 1'b1;
					end
					order[cmd.set] <= markNewest(cmd.way, order[cmd.set]);
				end
				cachePkg::opWriteHit, cachePkg::opReadHit: begin
					order[cmd.set] <= markNewest(cmd.way, order[cmd.set]);
				end
				cachePkg::opPurgeLine: begin
					for (int w = 0; w < `CACHE_WAYS; w++) begin
						if (cmd.way[w])
							valid[w][cmd.set] <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire
